/* hdl/pwm_defines.svh */
`ifndef PWM_DEFINES_SVH
`define PWM_DEFINES_SVH

// Carrier and duty scale
`define PWM_CARRIER_MAX    100   // Carrier peak, also full duty
`define PWM_SINE_MID       50    // Duty at 0 degrees
`define PWM_CARRIER_START  0     // Carrier value after reset

// Angle word, 4096 counts per sine period
`define PWM_ANGLE_W        12
`define PWM_PHASE_OFFSET   1365  // 120 degrees in angle counts

// Output conditioning
`define PWM_FILTER_N       5     // Stable cycles before a level passes
`define PWM_DEAD_TIME      2     // Extra cycles on every rising gate edge

`endif

/* hdl/pwm_pkg.sv */
`include "pwm_defines.svh"

package pwm_pkg;

    // Duty and carrier share one scale, 0 to PWM_CARRIER_MAX
    typedef logic [6:0] duty_t;

    // One full sine period over the whole word
    typedef logic [`PWM_ANGLE_W-1:0] angle_t;

    // One gate level per phase
    typedef struct packed {
        logic a;   // Phase A
        logic b;   // Phase B
        logic c;   // Phase C
    } gate_word_t;

endpackage

/* hdl/phase_if.sv */
interface phase_if;

    pwm_pkg::duty_t duty_a;    // Phase A duty
    pwm_pkg::duty_t duty_b;    // Phase B duty, lags A by 120 degrees
    pwm_pkg::duty_t duty_c;    // Phase C duty, lags A by 240 degrees
    pwm_pkg::duty_t carrier;   // Shared triangular carrier

    // Sine table side
    modport lut (
        output duty_a,
        output duty_b,
        output duty_c
    );

    // Carrier counter side
    modport gen (
        output carrier
    );

    // Comparator reads everything
    modport cmp (
        input duty_a,
        input duty_b,
        input duty_c,
        input carrier
    );

endinterface

/* hdl/sine_lut.sv */
`include "pwm_defines.svh"

module sine_lut (
    input  logic            clk,
    input  logic            arst_n,
    input  pwm_pkg::angle_t angle,
    phase_if.lut            phase
);

    pwm_pkg::angle_t angle_b;
    pwm_pkg::angle_t angle_c;

    // Amplitude 50*sin(k*5.625 deg), k = 0..16, rounded
    function automatic logic [5:0] quarter_sine(input logic [4:0] idx);
        case (idx)
            5'd0:    return 6'd0;
            5'd1:    return 6'd5;
            5'd2:    return 6'd10;
            5'd3:    return 6'd15;
            5'd4:    return 6'd19;
            5'd5:    return 6'd24;
            5'd6:    return 6'd28;
            5'd7:    return 6'd32;
            5'd8:    return 6'd35;
            5'd9:    return 6'd39;
            5'd10:   return 6'd42;
            5'd11:   return 6'd44;
            5'd12:   return 6'd46;
            5'd13:   return 6'd48;
            5'd14:   return 6'd49;
            5'd15:   return 6'd50;
            5'd16:   return 6'd50;
            default: return 6'd0;
        endcase
    endfunction

    // Full period from the quarter table by mirroring
    function automatic pwm_pkg::duty_t angle_to_duty(input pwm_pkg::angle_t ang);
        logic [1:0] quadrant;
        logic [3:0] step;
        logic [4:0] idx;
        logic [5:0] amp;
        quadrant = ang[`PWM_ANGLE_W-1 -: 2];
        step     = ang[`PWM_ANGLE_W-3 -: 4];   // 64 counts per table step
        if (quadrant[0]) begin
            idx = 5'd16 - {1'b0, step};        // Falling half of the lobe
        end else begin
            idx = {1'b0, step};
        end
        amp = quarter_sine(idx);
        if (quadrant[1]) begin
            return pwm_pkg::duty_t'(`PWM_SINE_MID - amp);   // Negative lobe
        end
        return pwm_pkg::duty_t'(`PWM_SINE_MID + amp);
    endfunction

    assign angle_b = angle - pwm_pkg::angle_t'(`PWM_PHASE_OFFSET);
    // Minus 2731 modulo 4096 is the same as plus 1365
    assign angle_c = angle + pwm_pkg::angle_t'(`PWM_PHASE_OFFSET);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase.duty_a <= pwm_pkg::duty_t'(`PWM_SINE_MID);
            phase.duty_b <= pwm_pkg::duty_t'(`PWM_SINE_MID);
            phase.duty_c <= pwm_pkg::duty_t'(`PWM_SINE_MID);
        end else begin
            phase.duty_a <= angle_to_duty(angle);
            phase.duty_b <= angle_to_duty(angle_b);
            phase.duty_c <= angle_to_duty(angle_c);
        end
    end

endmodule

/* hdl/carrier_gen.sv */
`include "pwm_defines.svh"

module carrier_gen (
    input  logic clk,
    input  logic arst_n,
    phase_if.gen phase
);

    logic count_up;    // Direction flag, 1 while rising
    logic at_peak;
    logic at_valley;

    assign at_peak   = (phase.carrier == pwm_pkg::duty_t'(`PWM_CARRIER_MAX));
    assign at_valley = (phase.carrier == '0);

    // 0 up to the peak and back down, 200 cycles per period
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase.carrier <= pwm_pkg::duty_t'(`PWM_CARRIER_START);
            count_up      <= 1'b1;
        end else if (count_up) begin
            if (at_peak) begin
                phase.carrier <= phase.carrier - 1'b1;   // Turn around at the top
                count_up      <= 1'b0;
            end else begin
                phase.carrier <= phase.carrier + 1'b1;
            end
        end else begin
            if (at_valley) begin
                phase.carrier <= phase.carrier + 1'b1;   // Turn around at zero
                count_up      <= 1'b1;
            end else begin
                phase.carrier <= phase.carrier - 1'b1;
            end
        end
    end

endmodule

/* hdl/pwm_compare.sv */
module pwm_compare (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                shoot,
    phase_if.cmp                phase,
    output pwm_pkg::gate_word_t raw_gate
);

    pwm_pkg::gate_word_t hit;   // Duty at or above carrier

    always_comb begin
        hit.a = (phase.duty_a >= phase.carrier);
        hit.b = (phase.duty_b >= phase.carrier);
        hit.c = (phase.duty_c >= phase.carrier);
    end

    // Shoot low forces every high side request off
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raw_gate <= '0;
        end else begin
            raw_gate.a <= shoot & hit.a;
            raw_gate.b <= shoot & hit.b;
            raw_gate.c <= shoot & hit.c;
        end
    end

endmodule

/* hdl/glitch_filter.sv */
`include "pwm_defines.svh"

module glitch_filter (
    input  logic                clk,
    input  logic                arst_n,
    input  pwm_pkg::gate_word_t in_gate,
    output pwm_pkg::gate_word_t out_gate
);

    localparam int NUM_BITS = $bits(pwm_pkg::gate_word_t);
    localparam int CNT_W    = $clog2(`PWM_FILTER_N);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PWM_FILTER_N - 1);

    logic [NUM_BITS-1:0] in_bits;
    logic [NUM_BITS-1:0] out_bits;

    assign in_bits  = in_gate;
    assign out_gate = pwm_pkg::gate_word_t'(out_bits);

    for (genvar i = 0; i < NUM_BITS; i++) begin : g_bit
        logic             last_q;     // Input seen on the previous cycle
        logic             level_q;    // Filtered level
        logic [CNT_W-1:0] stable_q;   // Cycles the input has held
        logic [CNT_W-1:0] stable_d;

        always_comb begin
            if (in_bits[i] != last_q) begin
                stable_d = '0;   // Input moved, start over
            end else if (stable_q == CNT_LAST) begin
                stable_d = stable_q;
            end else begin
                stable_d = stable_q + 1'b1;
            end
        end

        // Level passes on the cycle the count reaches its end
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                last_q   <= 1'b0;
                stable_q <= '0;
                level_q  <= 1'b0;
            end else begin
                last_q   <= in_bits[i];
                stable_q <= stable_d;
                if (stable_d == CNT_LAST) begin
                    level_q <= last_q;
                end
            end
        end

        assign out_bits[i] = level_q;
    end

endmodule

/* hdl/dead_time.sv */
`include "pwm_defines.svh"

module dead_time (
    input  logic                clk,
    input  logic                arst_n,
    input  pwm_pkg::gate_word_t in_gate,
    output pwm_pkg::gate_word_t high_side,
    output pwm_pkg::gate_word_t low_side
);

    localparam int NUM_PH = $bits(pwm_pkg::gate_word_t);
    localparam int NUM_SIDES = 2 * NUM_PH;
    localparam int CNT_W = $clog2(`PWM_DEAD_TIME + 1);
    localparam logic [CNT_W-1:0] DT_CNT = CNT_W'(`PWM_DEAD_TIME);

    logic [NUM_PH-1:0]    in_bits;
    logic [NUM_SIDES-1:0] side_req;   // Low sides in the upper half
    logic [NUM_SIDES-1:0] side_on;

    assign in_bits  = in_gate;
    assign side_req = {~in_bits, in_bits};

    // Same rule for all six switches, each watching its partner
    for (genvar i = 0; i < NUM_SIDES; i++) begin : g_side
        localparam int OPP = (i + NUM_PH) % NUM_SIDES;

        logic [CNT_W-1:0] wait_q;   // Cycles the request has been steady
        logic             on_q;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                wait_q <= '0;
                on_q   <= 1'b0;
            end else if (!side_req[i]) begin
                wait_q <= '0;   // Turn off at once
                on_q   <= 1'b0;
            end else if (wait_q != DT_CNT) begin
                wait_q <= wait_q + 1'b1;
            end else if (!side_on[OPP]) begin
                on_q <= 1'b1;   // Dead time served, partner is off
            end
        end

        assign side_on[i] = on_q;
    end

    assign high_side = pwm_pkg::gate_word_t'(side_on[NUM_PH-1:0]);
    assign low_side  = pwm_pkg::gate_word_t'(side_on[NUM_SIDES-1:NUM_PH]);

endmodule

/* hdl/pwm_modulator.sv */
`include "pwm_defines.svh"

module pwm_modulator (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   shoot,   // Enables switching
    input  logic [`PWM_ANGLE_W-1:0] angle,  // Point on the sine period
    output logic                   g1_a,    // Phase A high side
    output logic                   g2_a,    // Phase A low side
    output logic                   g1_b,
    output logic                   g2_b,
    output logic                   g1_c,
    output logic                   g2_c
);

    pwm_pkg::gate_word_t raw_gate;
    pwm_pkg::gate_word_t filt_gate;
    pwm_pkg::gate_word_t high_side;
    pwm_pkg::gate_word_t low_side;

    phase_if u_phase_if ();

    sine_lut u_sine_lut (
        .clk    (clk),
        .arst_n (arst_n),
        .angle  (angle),
        .phase  (u_phase_if.lut)
    );

    carrier_gen u_carrier_gen (
        .clk    (clk),
        .arst_n (arst_n),
        .phase  (u_phase_if.gen)
    );

    pwm_compare u_pwm_compare (
        .clk      (clk),
        .arst_n   (arst_n),
        .shoot    (shoot),
        .phase    (u_phase_if.cmp),
        .raw_gate (raw_gate)
    );

    glitch_filter u_glitch_filter (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_gate  (raw_gate),
        .out_gate (filt_gate)
    );

    dead_time u_dead_time (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_gate   (filt_gate),
        .high_side (high_side),
        .low_side  (low_side)
    );

    assign g1_a = high_side.a;
    assign g2_a = low_side.a;
    assign g1_b = high_side.b;
    assign g2_b = low_side.b;
    assign g1_c = high_side.c;
    assign g2_c = low_side.c;

endmodule

/* testbench/pwm_modulator_checker.sv */
`include "pwm_defines.svh"

module pwm_modulator_checker (
    input logic clk,
    input logic arst_n,
    input logic g1_a,
    input logic g2_a,
    input logic g1_b,
    input logic g2_b,
    input logic g1_c,
    input logic g2_c
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PH    = 3;
    localparam int MIN_PULSE = `PWM_FILTER_N - `PWM_DEAD_TIME;   // Filter width less rise delay

    logic [2*NUM_PH-1:0] gates;             // High sides in the lower half
    int unsigned         fail_count = 0;    // Read by the testbench at the end

    assign gates = {g2_c, g2_b, g2_a, g1_c, g1_b, g1_a};

    a_reset_low: assert property (@(posedge clk) !arst_n |-> gates == '0)
        else begin
            $error("A gate output is on while reset is active");
            fail_count++;
        end

    for (genvar p = 0; p < NUM_PH; p++) begin : g_phase
        // Shoot-through guard
        a_complement: assert property (@(posedge clk) !(gates[p] && gates[p+NUM_PH]))
            else begin
                $error("Both switches of phase %0d are on together", p);
                fail_count++;
            end
    end

    for (genvar i = 0; i < 2*NUM_PH; i++) begin : g_switch
        localparam int OPP = (i + NUM_PH) % (2*NUM_PH);   // Other switch of the leg

        int high_run;   // Samples this switch has been on
        int idle_run;   // Samples both switches of the leg have been off

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                high_run <= 0;
                idle_run <= 0;
            end else begin
                if (!gates[i]) begin
                    high_run <= 0;
                end else if (high_run < MIN_PULSE) begin
                    high_run <= high_run + 1;
                end
                if (gates[i] || gates[OPP]) begin
                    idle_run <= 0;
                end else if (idle_run < `PWM_DEAD_TIME) begin
                    idle_run <= idle_run + 1;
                end
            end
        end

        // A switch may only close once the leg has been idle for the dead time
        a_dead_time: assert property (@(posedge clk) disable iff (!arst_n)
            $rose(gates[i]) |-> idle_run >= `PWM_DEAD_TIME)
            else begin
                $error("Switch %0d turned on before the dead time ran out", i);
                fail_count++;
            end

        a_pulse_width: assert property (@(posedge clk) disable iff (!arst_n)
            $fell(gates[i]) |-> high_run >= MIN_PULSE)
            else begin
                $error("Switch %0d produced a pulse shorter than %0d cycles", i, MIN_PULSE);
                fail_count++;
            end
    end

endmodule

/* testbench/pwm_modulator_tb.sv */
`include "pwm_defines.svh"

module pwm_modulator_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_CYC = 2 * `PWM_CARRIER_MAX;   // One carrier period
    localparam int RESET_CYC  = 5;
    localparam int SETTLE_CYC = 20;
    localparam int HOLD_CYC   = 40;
    localparam int NUM_RAND   = 4;
    localparam int ANGLE_SPAN = 1 << `PWM_ANGLE_W;
    localparam int AMP        = `PWM_CARRIER_MAX - `PWM_SINE_MID;
    localparam int OFF_CYC    = 1 + `PWM_FILTER_N + 1;   // Compare, filter, dead-time fall
    localparam int ON_CYC     = OFF_CYC + `PWM_DEAD_TIME;
    localparam int TOTAL_CYC  = (RESET_CYC + SETTLE_CYC + HOLD_CYC)
                              + 2 * (SETTLE_CYC + 2 * PERIOD_CYC)
                              + (1 + NUM_RAND) * (4 * PERIOD_CYC + SETTLE_CYC)
                              + (SETTLE_CYC + PERIOD_CYC + ON_CYC + HOLD_CYC);
    localparam int TIMEOUT_CYC = TOTAL_CYC + TOTAL_CYC / 5;

    logic                    clk;
    logic                    arst_n;
    logic                    shoot;
    logic [`PWM_ANGLE_W-1:0] angle;
    logic                    g1_a;
    logic                    g2_a;
    logic                    g1_b;
    logic                    g2_b;
    logic                    g1_c;
    logic                    g2_c;

    int    cycle_count = 0;
    int    test_errors;
    int    tests_passed = 0;
    int    tests_failed = 0;
    string test_name;

    pwm_modulator u_pwm_modulator (
        .clk    (clk),
        .arst_n (arst_n),
        .shoot  (shoot),
        .angle  (angle),
        .g1_a   (g1_a),
        .g2_a   (g2_a),
        .g1_b   (g1_b),
        .g2_b   (g2_b),
        .g1_c   (g1_c),
        .g2_c   (g2_c)
    );

    bind pwm_modulator pwm_modulator_checker u_pwm_modulator_checker (
        .clk    (clk),
        .arst_n (arst_n),
        .g1_a   (g1_a),
        .g2_a   (g2_a),
        .g1_b   (g1_b),
        .g2_b   (g2_b),
        .g1_c   (g1_c),
        .g2_c   (g2_c)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYC) begin
            $display("Run stopped after %0d cycles without finishing", TIMEOUT_CYC);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Sine rule 50 + 50*sin, sampled every 64 angle counts like the table
    function automatic int duty_of(input logic [`PWM_ANGLE_W-1:0] ang, input int ph);
        int  pos;
        real theta;
        pos   = int'(ang);
        if (ph == 1) begin
            pos = pos - `PWM_PHASE_OFFSET;
        end else if (ph == 2) begin
            pos = pos - (ANGLE_SPAN - `PWM_PHASE_OFFSET);   // C lags by 2731
        end
        pos   = (pos + ANGLE_SPAN) % ANGLE_SPAN;
        pos   = pos - pos % 64;
        theta = 2.0 * 3.14159265358979 * pos / ANGLE_SPAN;
        return $rtoi(`PWM_SINE_MID + AMP * $sin(theta) + 0.5);
    endfunction

    // Carrier sits at or below the duty for 2d+1 cycles of each period
    function automatic int edges_per_period(input int duty);
        int high_len;
        int low_len;
        high_len = 2 * duty + 1;
        low_len  = PERIOD_CYC - high_len;
        if (high_len >= `PWM_FILTER_N && low_len >= `PWM_FILTER_N) begin
            return 2;
        end
        return 0;   // Filter swallows the short level
    endfunction

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s passed", test_name);
        end else begin
            tests_failed++;
            $display("%s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic expect_bit(input string what, input logic expected, input logic actual);
        assert (actual === expected) else begin
            test_errors++;
            $display("** Error %s: %s expected %0b, actual %0b", test_name, what, expected,
                     actual);
        end
    endtask

    task automatic compare_count(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            test_errors++;
            $display("** Error %s: %s expected %0d, actual %0d", test_name, what, expected,
                     actual);
        end
    endtask

    task automatic high_sides_are(input logic level);
        expect_bit("g1_a", level, g1_a);
        expect_bit("g1_b", level, g1_b);
        expect_bit("g1_c", level, g1_c);
    endtask

    task automatic low_sides_are(input logic level);
        expect_bit("g2_a", level, g2_a);
        expect_bit("g2_b", level, g2_b);
        expect_bit("g2_c", level, g2_c);
    endtask

    // Only full duty or zero duty reach this task
    task automatic hold_extreme(input logic [`PWM_ANGLE_W-1:0] ang);
        logic full_on;
        full_on = (duty_of(ang, 0) >= `PWM_CARRIER_MAX);
        angle   = ang;
        repeat (SETTLE_CYC) @(negedge clk);
        repeat (2 * PERIOD_CYC) begin
            @(negedge clk);
            expect_bit("g1_a", full_on, g1_a);
            expect_bit("g2_a", !full_on, g2_a);
        end
    endtask

    task automatic count_switching(input logic [`PWM_ANGLE_W-1:0] ang);
        int         expected[3];
        int         edges[3];
        logic [2:0] prev;
        logic [2:0] now;
        string      letters;
        letters = "abc";
        angle   = ang;
        for (int ph = 0; ph < 3; ph++) begin
            expected[ph] = 3 * edges_per_period(duty_of(ang, ph));
            edges[ph]    = 0;
        end
        repeat (PERIOD_CYC + SETTLE_CYC) @(negedge clk);   // Let a full period flush through
        prev = {g1_c, g1_b, g1_a};
        repeat (3 * PERIOD_CYC) begin
            @(negedge clk);
            now = {g1_c, g1_b, g1_a};
            for (int ph = 0; ph < 3; ph++) begin
                if (now[ph] != prev[ph]) begin
                    edges[ph]++;
                end
            end
            prev = now;
        end
        for (int ph = 0; ph < 3; ph++) begin
            compare_count($sformatf("g1_%c edges at angle %0d", letters[ph], ang),
                          expected[ph], edges[ph]);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int unsigned assert_fails;

        clk    = 1'b0;
        arst_n = 1'b0;
        shoot  = 1'b0;
        angle  = '0;
        void'($urandom(32'h5d946bca));

        begin_test("reset_state");
        repeat (RESET_CYC) begin
            @(negedge clk);
            high_sides_are(1'b0);
            low_sides_are(1'b0);
        end
        arst_n = 1'b1;
        repeat (SETTLE_CYC) @(negedge clk);
        repeat (HOLD_CYC) begin
            @(negedge clk);
            high_sides_are(1'b0);
            low_sides_are(1'b1);   // Idle bridge holds the low sides on
        end
        end_test();

        begin_test("extreme_duty");
        shoot = 1'b1;
        hold_extreme(`PWM_ANGLE_W'(1024));
        hold_extreme(`PWM_ANGLE_W'(3072));
        end_test();

        begin_test("mid_duty_switching");
        count_switching('0);
        repeat (NUM_RAND) begin
            rnd = $urandom();
            count_switching(rnd[`PWM_ANGLE_W-1:0]);
        end
        end_test();

        begin_test("shoot_release");
        angle = '0;
        repeat (SETTLE_CYC) @(negedge clk);
        while (!g1_a) @(negedge clk);   // Release while phase A is conducting
        shoot = 1'b0;
        for (int k = 1; k <= ON_CYC + HOLD_CYC; k++) begin
            @(negedge clk);
            if (k >= OFF_CYC) begin
                high_sides_are(1'b0);
            end
            if (k >= ON_CYC) begin
                low_sides_are(1'b1);
            end
        end
        end_test();

        assert_fails = u_pwm_modulator.u_pwm_modulator_checker.fail_count;
        if (assert_fails != 0) begin
            $display("Gate output assertions failed %0d times", assert_fails);
        end
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d", tests_passed,
                 tests_failed, assert_fails);
        if (tests_failed == 0 && assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* pwm_modulator.f */
+incdir+hdl
hdl/pwm_pkg.sv
hdl/phase_if.sv
hdl/sine_lut.sv
hdl/carrier_gen.sv
hdl/pwm_compare.sv
hdl/glitch_filter.sv
hdl/dead_time.sv
hdl/pwm_modulator.sv
testbench/pwm_modulator_checker.sv
testbench/pwm_modulator_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and judge the result from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pwm_modulator_tb \
    -f pwm_modulator.f -o pwm_modulator_sim > build.log 2>&1 \
    && ./obj_dir/pwm_modulator_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -sqx "TEST OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
